// File: src/ahblPkg.sv
/*
    AHB-Lite peripheral package
    bus request and slave response structs, peripheral select,
    memory map constants and register offsets shared by the subsystem
*/

package ahblPkg;

    // ------------------------------------------------------------------
    // bus structs
    // ------------------------------------------------------------------

    // address-phase request from the master
    typedef struct packed {
        logic [31:0] addr;
        logic [1:0]  trans;
        logic [2:0]  size;
        logic        write;
    } ahbReq_t;

    // data-phase answer of one slave
    typedef struct packed {
        logic [31:0] rData;
        logic        readyOut;
    } slaveResp_t;

    // one-hot peripheral select, all zero outside the region
    typedef struct packed {
        logic gpio;
        logic timer;
        logic unmapped;
    } periphSel_t;

    // ------------------------------------------------------------------
    // memory map
    // ------------------------------------------------------------------

    localparam logic [3:0]  REGION_PERIPH = 4'h4;   // addr[31:28]
    localparam logic [2:0]  SLOT_GPIO     = 3'd0;   // addr[26:24]
    localparam logic [2:0]  SLOT_TIMER    = 3'd3;

    // register offsets on addr[3:2]
    localparam logic [1:0]  OFS_GPIO_IN    = 2'd0;
    localparam logic [1:0]  OFS_GPIO_OUT   = 2'd1;
    localparam logic [1:0]  OFS_GPIO_OE    = 2'd2;
    localparam logic [1:0]  OFS_TMR_LOAD   = 2'd0;
    localparam logic [1:0]  OFS_TMR_CTRL   = 2'd1;
    localparam logic [1:0]  OFS_TMR_COUNT  = 2'd2;
    localparam logic [1:0]  OFS_TMR_STATUS = 2'd3;

    // default slave pattern
    localparam logic [31:0] UNMAPPED_DATA = 32'hBADDBEEF;
    localparam logic [1:0]  HTRANS_NONSEQ = 2'b10;

endpackage

// File: src/ahblSplitter.sv
/*
    Peripheral address decoder
    turns the address phase into a one-hot select for GPIO, timer
    or the default slave; purely combinational
*/

module ahblSplitter (
    input  ahblPkg::ahbReq_t   busReq,
    output ahblPkg::periphSel_t periphSel
);
    import ahblPkg::*;

    // ------------------------------------------------------------------
    // address fields
    // ------------------------------------------------------------------

    logic [3:0] regionField;
    logic [2:0] slotField;
    logic       regionHit;

    assign regionField = busReq.addr[31:28];
    assign slotField   = busReq.addr[26:24];

    // only the peripheral nibble is decoded here
    assign regionHit = (regionField == REGION_PERIPH);

    // ------------------------------------------------------------------
    // slot decode
    // ------------------------------------------------------------------

    always_comb begin
        periphSel = '0;
        if (regionHit) begin
            case (slotField)
                SLOT_GPIO: begin
                    periphSel.gpio = 1'b1;
                end
                SLOT_TIMER: begin
                    periphSel.timer = 1'b1;
                end
                default: begin
                    // anything else in the region goes to the default slave
                    periphSel.unmapped = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: src/ahblGpio.sv
/*
    32-bit GPIO slave
    output and output-enable registers plus a two-flop synchronised
    copy of the input pins, zero wait states
*/

module ahblGpio (
    input  logic                HCLK,
    input  logic                reset,
    input  ahblPkg::ahbReq_t    busReq,
    input  logic                hSel,
    input  logic                hReady,
    input  logic [31:0]         hWData,
    output ahblPkg::slaveResp_t resp,
    input  logic [31:0]         gpioIn,
    output logic [31:0]         gpioOut,
    output logic [31:0]         gpioOe
);
    import ahblPkg::*;

    logic        addrPhase;
    logic        dataPhaseQ;
    logic        writeQ;
    logic [1:0]  ofsQ;
    logic        wrEn;
    logic [31:0] inMeta;
    logic [31:0] inSync;

    // ------------------------------------------------------------------
    // address phase capture
    // ------------------------------------------------------------------

    assign addrPhase = hSel && busReq.trans[1] && hReady;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataPhaseQ <= 1'b0;
            writeQ     <= 1'b0;
            ofsQ       <= '0;
        end else if (hReady) begin
            dataPhaseQ <= addrPhase;
            if (addrPhase) begin
                writeQ <= busReq.write;
                ofsQ   <= busReq.addr[3:2];
            end
        end
    end

    assign wrEn = dataPhaseQ && writeQ;

    // ------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------

    always_ff @(posedge HCLK) begin
        if (reset) begin
            gpioOut <= '0;
            gpioOe  <= '0;
        end else if (wrEn) begin
            case (ofsQ)
                OFS_GPIO_OUT: gpioOut <= hWData;
                OFS_GPIO_OE:  gpioOe  <= hWData;
                default: ;
            endcase
        end
    end

    // pin synchroniser
    always_ff @(posedge HCLK) begin
        inMeta <= gpioIn;
        inSync <= inMeta;
    end

    // ------------------------------------------------------------------
    // read data
    // ------------------------------------------------------------------

    always_comb begin
        resp.readyOut = 1'b1;
        case (ofsQ)
            OFS_GPIO_IN:  resp.rData = inSync;
            OFS_GPIO_OUT: resp.rData = gpioOut;
            OFS_GPIO_OE:  resp.rData = gpioOe;
            default:      resp.rData = '0;
        endcase
    end

endmodule

// File: src/ahblTimer.sv
/*
    Down-counting timer slave
    LOAD, CTRL, COUNT and STATUS registers; the count reloads on
    reaching zero and sets a sticky flag that drives the interrupt
*/

module ahblTimer (
    input  logic                HCLK,
    input  logic                reset,
    input  ahblPkg::ahbReq_t    busReq,
    input  logic                hSel,
    input  logic                hReady,
    input  logic [31:0]         hWData,
    output ahblPkg::slaveResp_t resp,
    output logic                timerIrq
);
    import ahblPkg::*;

    logic        addrPhase;
    logic        dataPhaseQ;
    logic        writeQ;
    logic [1:0]  ofsQ;
    logic        wrEn;

    logic [31:0] loadQ;
    logic        enableQ;
    logic [31:0] countQ;
    logic        flagQ;
    logic        expire;

    // ------------------------------------------------------------------
    // address phase capture
    // ------------------------------------------------------------------

    assign addrPhase = hSel && busReq.trans[1] && hReady;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataPhaseQ <= 1'b0;
            writeQ     <= 1'b0;
            ofsQ       <= '0;
        end else if (hReady) begin
            dataPhaseQ <= addrPhase;
            if (addrPhase) begin
                writeQ <= busReq.write;
                ofsQ   <= busReq.addr[3:2];
            end
        end
    end

    assign wrEn = dataPhaseQ && writeQ;

    // ------------------------------------------------------------------
    // counter
    // ------------------------------------------------------------------

    assign expire = enableQ && (countQ == '0);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            loadQ   <= '0;
            countQ  <= '0;
            enableQ <= 1'b0;
        end else begin
            if (wrEn && ofsQ == OFS_TMR_LOAD) begin
                // a new load restarts the count
                loadQ  <= hWData;
                countQ <= hWData;
            end else if (expire) begin
                countQ <= loadQ;
            end else if (enableQ) begin
                countQ <= countQ - 32'd1;
            end
            if (wrEn && ofsQ == OFS_TMR_CTRL) begin
                enableQ <= hWData[0];
            end
        end
    end

    // sticky expiry flag, expiry wins over a clear in the same cycle
    always_ff @(posedge HCLK) begin
        if (reset) begin
            flagQ <= 1'b0;
        end else if (expire) begin
            flagQ <= 1'b1;
        end else if (wrEn && ofsQ == OFS_TMR_STATUS && hWData[0]) begin
            flagQ <= 1'b0;
        end
    end

    assign timerIrq = flagQ;

    // ------------------------------------------------------------------
    // read data
    // ------------------------------------------------------------------

    always_comb begin
        resp.readyOut = 1'b1;
        case (ofsQ)
            OFS_TMR_LOAD:   resp.rData = loadQ;
            OFS_TMR_CTRL:   resp.rData = {31'd0, enableQ};
            OFS_TMR_COUNT:  resp.rData = countQ;
            OFS_TMR_STATUS: resp.rData = {31'd0, flagQ};
            default:        resp.rData = '0;
        endcase
    end

endmodule

// File: src/ahblReadMux.sv
/*
    Read-return block
    holds the data-phase select and steers read data and ready
    back to the master; includes the default slave
*/

module ahblReadMux (
    input  logic                HCLK,
    input  logic                reset,
    input  ahblPkg::periphSel_t periphSel,
    input  logic                hReady,
    input  ahblPkg::slaveResp_t gpioResp,
    input  ahblPkg::slaveResp_t timerResp,
    output logic [31:0]         hRData,
    output logic                hReadyOut
);
    import ahblPkg::*;

    periphSel_t selQ;
    slaveResp_t muxResp;

    // select follows the address phase only when the bus advances
    always_ff @(posedge HCLK) begin
        if (reset) begin
            selQ <= '0;
        end else if (hReady) begin
            selQ <= periphSel;
        end
    end

    // ------------------------------------------------------------------
    // response steering
    // ------------------------------------------------------------------

    always_comb begin
        muxResp.rData    = '0;
        muxResp.readyOut = 1'b1;
        if (selQ.gpio) begin
            muxResp = gpioResp;
        end else if (selQ.timer) begin
            muxResp = timerResp;
        end else if (selQ.unmapped) begin
            // default slave answers at once with a fixed pattern
            muxResp.rData = UNMAPPED_DATA;
        end
    end

    assign hRData    = muxResp.rData;
    assign hReadyOut = muxResp.readyOut;

endmodule

// File: src/periphSubsystem.sv
/*
    Peripheral subsystem top level
    address decode, GPIO and timer slaves and the read return,
    with returned ready fed back to the slaves as HREADY
*/

module periphSubsystem (
    input  logic             HCLK,
    input  logic             reset,
    input  ahblPkg::ahbReq_t busReq,
    input  logic [31:0]      hWData,
    output logic [31:0]      hRData,
    output logic             hReadyOut,
    input  logic [31:0]      gpioIn,
    output logic [31:0]      gpioOut,
    output logic [31:0]      gpioOe,
    output logic             timerIrq
);
    import ahblPkg::*;

    periphSel_t periphSel;
    slaveResp_t gpioResp;
    slaveResp_t timerResp;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------

    ahblSplitter splitter (
        .busReq    (busReq),
        .periphSel (periphSel)
    );

    // ------------------------------------------------------------------
    // slaves
    // ------------------------------------------------------------------

    ahblGpio gpio (
        .HCLK    (HCLK),
        .reset   (reset),
        .busReq  (busReq),
        .hSel    (periphSel.gpio),
        .hReady  (hReadyOut),
        .hWData  (hWData),
        .resp    (gpioResp),
        .gpioIn  (gpioIn),
        .gpioOut (gpioOut),
        .gpioOe  (gpioOe)
    );

    ahblTimer timer (
        .HCLK     (HCLK),
        .reset    (reset),
        .busReq   (busReq),
        .hSel     (periphSel.timer),
        .hReady   (hReadyOut),
        .hWData   (hWData),
        .resp     (timerResp),
        .timerIrq (timerIrq)
    );

    // ------------------------------------------------------------------
    // read return
    // ------------------------------------------------------------------

    ahblReadMux readMux (
        .HCLK      (HCLK),
        .reset     (reset),
        .periphSel (periphSel),
        .hReady    (hReadyOut),
        .gpioResp  (gpioResp),
        .timerResp (timerResp),
        .hRData    (hRData),
        .hReadyOut (hReadyOut)
    );

endmodule

// File: sim/periphTb.sv
/*
    Testbench for the peripheral subsystem
    acts as the AHB-Lite master, keeps a small register model and
    checks GPIO, timer and default slave with assertions
*/

module periphTb;
    import ahblPkg::*;

    localparam int READY_TIMEOUT = 20;

    logic        HCLK;
    logic        reset;
    ahbReq_t     busReq;
    logic [31:0] hWData;
    logic [31:0] hRData;
    logic        hReadyOut;
    logic [31:0] gpioIn;
    logic [31:0] gpioOut;
    logic [31:0] gpioOe;
    logic        timerIrq;

    integer      seed;
    logic [31:0] modelOut;
    logic [31:0] modelOe;
    logic [31:0] modelLoad;
    logic        modelEnable;
    logic        portCheckOn;

    periphSubsystem dut (
        .HCLK      (HCLK),
        .reset     (reset),
        .busReq    (busReq),
        .hWData    (hWData),
        .hRData    (hRData),
        .hReadyOut (hReadyOut),
        .gpioIn    (gpioIn),
        .gpioOut   (gpioOut),
        .gpioOe    (gpioOe),
        .timerIrq  (timerIrq)
    );

    initial HCLK = 1'b0;
    always #5 HCLK = ~HCLK;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    task automatic stopRun;
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    // inputs change 1 unit after the rising edge
    task automatic nextCycle;
        @(posedge HCLK);
        #1;
    endtask

    task automatic waitReady;
        int waited;
        begin
            waited = 0;
            while (hReadyOut !== 1'b1) begin
                if (waited >= READY_TIMEOUT) begin
                    $display("timeout at %0t, hReadyOut never returned high", $time);
                    stopRun();
                end
                nextCycle();
                waited++;
            end
        end
    endtask

    task automatic waitIrq(input int limit, input int already);
        int cycles;
        begin
            cycles = already;
            while (timerIrq !== 1'b1) begin
                if (cycles >= limit) begin
                    $display("timeout at %0t, timerIrq did not rise in %0d cycles", $time, limit);
                    stopRun();
                end
                nextCycle();
                cycles++;
            end
        end
    endtask

    function automatic logic [31:0] regAddr(input logic [2:0] slot, input logic [1:0] ofs);
        return {REGION_PERIPH, 1'b0, slot, 20'h00000, ofs, 2'b00};
    endfunction

    // register model, updated when a write's data phase completes
    function automatic void modelWrite(input logic [31:0] addr, input logic [31:0] data);
        if (addr[31:28] == REGION_PERIPH && addr[26:24] == SLOT_GPIO) begin
            if (addr[3:2] == OFS_GPIO_OUT)
                modelOut = data;
            else if (addr[3:2] == OFS_GPIO_OE)
                modelOe = data;
        end else if (addr[31:28] == REGION_PERIPH && addr[26:24] == SLOT_TIMER) begin
            if (addr[3:2] == OFS_TMR_LOAD)
                modelLoad = data;
            else if (addr[3:2] == OFS_TMR_CTRL)
                modelEnable = data[0];
        end
    endfunction

    task automatic startTransfer(input logic [31:0] addr, input logic write);
        busReq.addr  = addr;
        busReq.trans = HTRANS_NONSEQ;
        busReq.size  = 3'b010;
        busReq.write = write;
    endtask

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        waitReady();
        startTransfer(addr, 1'b1);
        nextCycle();
        busReq.trans = 2'b00;
        hWData = data;
        waitReady();
        nextCycle();
        modelWrite(addr, data);
    endtask

    task automatic readWord(input logic [31:0] addr, output logic [31:0] rData);
        waitReady();
        startTransfer(addr, 1'b0);
        nextCycle();
        busReq.trans = 2'b00;
        waitReady();
        rData = hRData;
        nextCycle();
    endtask

    // read address phase overlaps the write data phase
    task automatic writeThenRead(input logic [31:0] addr, input logic [31:0] data,
                                 output logic [31:0] rData);
        waitReady();
        startTransfer(addr, 1'b1);
        nextCycle();
        hWData = data;
        startTransfer(addr, 1'b0);
        waitReady();
        nextCycle();
        modelWrite(addr, data);
        busReq.trans = 2'b00;
        waitReady();
        rData = hRData;
        nextCycle();
    endtask

    // ports and ready checked mid-cycle against the model
    always @(negedge HCLK) begin
        if (portCheckOn) begin
            checkWord("gpioOut", modelOut, gpioOut);
            checkWord("gpioOe", modelOe, gpioOe);
            checkWord("hReadyOut", 32'd1, {31'd0, hReadyOut});
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    initial begin : mainSeq
        logic [31:0] value;
        logic [31:0] rd;
        logic [31:0] loadN;
        seed = 91;
        reset = 1'b1;
        busReq = '0;
        hWData = '0;
        gpioIn = '0;
        modelOut = '0;
        modelOe = '0;
        modelLoad = '0;
        modelEnable = 1'b0;
        portCheckOn = 1'b0;
        repeat (5) @(posedge HCLK);
        #1;
        reset = 1'b0;

        checkWord("gpioOut", 32'd0, gpioOut);
        checkWord("gpioOe", 32'd0, gpioOe);
        checkWord("timerIrq", 32'd0, {31'd0, timerIrq});
        checkWord("hReadyOut", 32'd1, {31'd0, hReadyOut});
        portCheckOn = 1'b1;

        // GPIO output registers
        for (int i = 0; i < 4; i++) begin
            value = $random(seed);
            writeWord(regAddr(SLOT_GPIO, OFS_GPIO_OUT), value);
            value = $random(seed);
            writeWord(regAddr(SLOT_GPIO, OFS_GPIO_OE), value);
            readWord(regAddr(SLOT_GPIO, OFS_GPIO_OUT), rd);
            checkWord("hRData gpio OUT", modelOut, rd);
            readWord(regAddr(SLOT_GPIO, OFS_GPIO_OE), rd);
            checkWord("hRData gpio OE", modelOe, rd);
        end
        value = $random(seed);
        writeThenRead(regAddr(SLOT_GPIO, OFS_GPIO_OUT), value, rd);
        checkWord("hRData gpio OUT back-to-back", value, rd);

        // GPIO input through the synchroniser
        for (int i = 0; i < 4; i++) begin
            value = $random(seed);
            gpioIn = value;
            repeat (3) nextCycle();
            readWord(regAddr(SLOT_GPIO, OFS_GPIO_IN), rd);
            checkWord("hRData gpio IN", value, rd);
        end

        // timer expiry and flag clear
        loadN = 32'd8 + ($random(seed) & 32'h7);
        writeWord(regAddr(SLOT_TIMER, OFS_TMR_LOAD), loadN);
        writeWord(regAddr(SLOT_TIMER, OFS_TMR_CTRL), 32'd1);
        readWord(regAddr(SLOT_TIMER, OFS_TMR_COUNT), rd);
        assert (rd <= loadN) else begin
            $display("[ERROR] t=%0t hRData timer COUNT expected <= %h actual %h",
                     $time, loadN, rd);
            stopRun();
        end
        waitIrq(loadN + 2, 2);
        readWord(regAddr(SLOT_TIMER, OFS_TMR_STATUS), rd);
        checkWord("hRData timer STATUS", 32'd1, rd);
        writeWord(regAddr(SLOT_TIMER, OFS_TMR_STATUS), 32'd1);
        checkWord("timerIrq", 32'd0, {31'd0, timerIrq});
        waitIrq(loadN + 2, 0);

        // default slave, sub-slot 5
        readWord(regAddr(3'd5, 2'd0), rd);
        checkWord("hRData unmapped", UNMAPPED_DATA, rd);
        // every offset, bit 0 clear so a stray CTRL write would stop the timer
        for (int i = 0; i < 4; i++) begin
            value = $random(seed) & 32'hFFFF_FFFE;
            writeWord(regAddr(3'd5, i[1:0]), value);
        end
        readWord(regAddr(SLOT_GPIO, OFS_GPIO_OUT), rd);
        checkWord("hRData gpio OUT", modelOut, rd);
        readWord(regAddr(SLOT_GPIO, OFS_GPIO_OE), rd);
        checkWord("hRData gpio OE", modelOe, rd);
        readWord(regAddr(SLOT_TIMER, OFS_TMR_LOAD), rd);
        checkWord("hRData timer LOAD", modelLoad, rd);
        readWord(regAddr(SLOT_TIMER, OFS_TMR_CTRL), rd);
        checkWord("hRData timer CTRL", {31'd0, modelEnable}, rd);

        nextCycle();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: hazardPeriph.f
src/ahblPkg.sv
src/ahblSplitter.sv
src/ahblGpio.sv
src/ahblTimer.sv
src/ahblReadMux.sv
src/periphSubsystem.sv
sim/periphTb.sv
